/* Makefile */
VERILATOR ?= verilator
TOP       ?= cartridge_tb
LINT_TOP  ?= cartridge_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qxF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+logic
logic/cart_pkg.sv
logic/crt_bank_loader.sv
logic/bank_table.sv
logic/cart_control.sv
logic/addr_translate.sv
logic/cartridge_top.sv
tests/cartridge_chk.sv
tests/cartridge_tb.sv

/* logic/addr_translate.sv */
/*
	CPU to SDRAM address translation.
	Purely combinational; ROM reads in the romL/romH windows are
	redirected into the CRT image at 0x100000, and writes to the
	missing RAM under romL in Ultimax mode are dropped.
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module addr_translate (
	input  logic                   reset_n,
	input  logic                   romL,		// $8000-$9FFF select
	input  logic                   romH,		// $A000-$BFFF or $E000-$FFFF select
	input  logic                   UMAXromH,	// VIC fetch from romH in Ultimax mode
	input  logic                   mem_write,
	input  logic [15:0]            addr_in,
	input  cart_pkg::bank_t        bank_lo,
	input  cart_pkg::bank_t        bank_hi,
	input  logic                   exrom_ovr,
	input  logic                   game_ovr,
	output cart_pkg::sdram_addr_t  addr_out,
	output logic                   mem_write_out
);

	localparam int BANK_BITS = $bits(cart_pkg::sdram_addr_t) - `CART_WINDOW_BITS;

	logic ultimax;

	// SDRAM window of a ROM bank, the base bit puts it above the RAM image
	function automatic logic [BANK_BITS-1:0] rom_bank(input cart_pkg::bank_t bank);
		rom_bank = BANK_BITS'({`CART_ROM_BASE_BIT, bank});
	endfunction

	assign ultimax = exrom_ovr && !game_ovr;

	// No RAM exists under romL in Ultimax mode
	assign mem_write_out = mem_write && !(romL && ultimax);

	// ********************
	// Address mapping
	// ********************
	always_comb begin
		addr_out = cart_pkg::sdram_addr_t'(addr_in);

		if (!reset_n) begin
			if (romH && !mem_write)
				addr_out[24:`CART_WINDOW_BITS] = rom_bank(bank_hi);
			if (romL && !mem_write)
				addr_out[24:`CART_WINDOW_BITS] = rom_bank(bank_lo);
			// Character ROM window, upper 4k of the romH bank
			if (UMAXromH)
				addr_out[24:`CART_WINDOW_BITS-1] = {rom_bank(bank_hi), 1'b1};
		end
	end

endmodule

/* logic/bank_table.sv */
/*
	Bank number tables for the loaded CRT image.
	One synchronous write port from the packet loader, low and high
	entries written independently; one asynchronous read port per
	table for the cartridge control.
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module bank_table (
	input  logic                        clk32,
	input  logic                        tbl_wr,
	input  logic [`CART_SLOT_BITS-1:0]  tbl_slot,
	input  cart_pkg::bank_t             tbl_lo,
	input  cart_pkg::bank_t             tbl_hi,
	input  logic                        tbl_lo_en,
	input  logic                        tbl_hi_en,
	input  logic [`CART_SLOT_BITS-1:0]  rd_slot,
	output cart_pkg::bank_t             rd_lo,
	output cart_pkg::bank_t             rd_hi
);

	// ********************
	// Storage
	// ********************
	cart_pkg::bank_t lo_banks [`CART_SLOTS];	// romL bank of each chip packet
	cart_pkg::bank_t hi_banks [`CART_SLOTS];	// romH bank of each chip packet

	always_ff @(posedge clk32) begin
		if (tbl_wr) begin
			if (tbl_lo_en)
				lo_banks[tbl_slot] <= tbl_lo;
			if (tbl_hi_en)
				hi_banks[tbl_slot] <= tbl_hi;
		end
	end

	// Reads are combinational so a bank select lands on the same edge
	assign rd_lo = lo_banks[rd_slot];
	assign rd_hi = hi_banks[rd_slot];

endmodule

/* logic/cart_cfg.svh */
/*
	Cartridge mapper configuration values.
	Included by the mapper RTL and by the testbench reference model
	for table depth, address windows and CRT load thresholds.
*/

`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// ********************
// Bank table geometry
// ********************
`define CART_SLOTS          64        // Chip packet slots kept in the table
`define CART_SLOT_BITS      6         // Index width for CART_SLOTS

// ********************
// SDRAM address layout
// ********************
`define CART_WINDOW_BITS    13        // Offset bits inside one 8k window
`define CART_ROM_BASE_BIT   1'b1      // Top bank bit, ROM space starts at 0x100000

// ********************
// CRT load rules
// ********************
`define CART_LO_LIMIT       'h8000    // Highest load address still counted as romL
`define CART_8K             'h2000    // Packets above this size fill romH too
`define CART_OCEAN_B_COUNT  32        // Ocean images beyond this many banks are type B

`endif

/* logic/cart_control.sv */
/*
	Per-type cartridge control.
	Holds the romL/romH bank registers and the EXROM/GAME overrides,
	boots them for the selected CRT type and updates them on CPU
	writes to the IOE area ($DExx).
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module cart_control (
	input  logic                        clk32,
	input  logic                        reset_n,
	input  cart_pkg::cart_type_e        cart_id,
	input  logic [7:0]                  cart_exrom,	// EXROM field of the CRT header
	input  logic [7:0]                  cart_game,	// GAME field of the CRT header
	input  logic [7:0]                  bank_cnt,
	input  logic                        IOE,
	input  logic                        mem_write,
	input  logic [15:0]                 addr_in,
	input  logic [7:0]                  data_in,
	input  cart_pkg::bank_t             rd_lo,
	input  cart_pkg::bank_t             rd_hi,
	output logic [`CART_SLOT_BITS-1:0]  rd_slot,
	output cart_pkg::bank_t             bank_lo,
	output cart_pkg::bank_t             bank_hi,
	output logic                        exrom_ovr,
	output logic                        game_ovr
);

	logic                 old_ioe;
	logic                 ioe_wr;		// First cycle of a CPU write into IOE
	logic                 is_ef;
	logic                 boot_done;
	cart_pkg::cart_type_e old_id;

	// ********************
	// IOE write strobe
	// ********************
	always_ff @(posedge clk32)
		old_ioe <= IOE;

	assign ioe_wr = IOE && !old_ioe && mem_write;

	assign is_ef = (cart_id == cart_pkg::CART_EASYFLASH) ||
	               (cart_id == cart_pkg::CART_XBANK);

	// EasyFlash bank register write picks a table slot straight from the data bus
	assign rd_slot = (is_ef && ioe_wr && !addr_in[1]) ? data_in[`CART_SLOT_BITS-1:0] : '0;

	// ********************
	// Bank and line registers
	// ********************
	always_ff @(posedge clk32) begin
		old_id    <= cart_id;
		boot_done <= 1'b1;

		if (reset_n || (old_id != cart_id)) begin
			bank_lo   <= '0;
			bank_hi   <= '0;
			exrom_ovr <= 1'b1;	// No cartridge visible
			game_ovr  <= 1'b1;
			boot_done <= 1'b0;
		end else begin
			case (cart_id)
				// 8k, 16k or Ultimax, lines fixed by the CRT header
				cart_pkg::CART_GENERIC: begin
					exrom_ovr <= cart_exrom[0];
					game_ovr  <= cart_game[0];
					bank_lo   <= rd_lo;
					bank_hi   <= rd_hi;
				end

				// Ocean: same bank mirrored at $8000 and $A000
				cart_pkg::CART_OCEAN: begin
					if (!boot_done) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b0;
					end
					if (ioe_wr) begin
						bank_lo <= cart_pkg::bank_t'(data_in[5:0]);
						bank_hi <= cart_pkg::bank_t'(data_in[5:0]);
					end
					// 512k type B runs in 8k mode, $A000 is RAM
					if (bank_cnt > 8'(`CART_OCEAN_B_COUNT))
						game_ovr <= 1'b1;
				end

				// Magic Desk: 8k mode, bit 7 switches the cartridge out
				cart_pkg::CART_MAGIC_DESK: begin
					if (!boot_done) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b1;
						bank_lo   <= '0;
					end
					if (ioe_wr) begin
						if (bank_cnt <= 8'd16)
							bank_lo <= cart_pkg::bank_t'(data_in[3:0]);
						else if (bank_cnt <= 8'd32)
							bank_lo <= cart_pkg::bank_t'(data_in[4:0]);
						else if (bank_cnt <= 8'd64)
							bank_lo <= cart_pkg::bank_t'(data_in[5:0]);
						else
							bank_lo <= data_in[6:0];
						exrom_ovr <= data_in[7];
					end
				end

				// EasyFlash boots Ultimax, XBank boots 16k
				cart_pkg::CART_EASYFLASH,
				cart_pkg::CART_XBANK: begin
					if (!boot_done) begin
						exrom_ovr <= (cart_id == cart_pkg::CART_EASYFLASH);
						game_ovr  <= 1'b0;
						bank_lo   <= rd_lo;
						bank_hi   <= rd_hi;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							// $DE02 mode register, jumper assumed in boot position
							game_ovr  <= ~data_in[0] & data_in[2];
							exrom_ovr <= ~data_in[1];
						end else begin
							bank_lo <= rd_lo;	// $DE00 bank register
							bank_hi <= rd_hi;
						end
					end
				end

				default: ;
			endcase
		end
	end

endmodule

/* logic/cart_pkg.sv */
/*
	Shared types for the cartridge mapper.
	Modules reference these by scoped name, e.g. cart_pkg::bank_t.
	Holds the bank number, the SDRAM address and the CRT hardware
	type codes that select the banking scheme.
*/

package cart_pkg;

	// ********************
	// Bank and address types
	// ********************

	// 8k bank number as stored in the bank table
	typedef logic [6:0] bank_t;

	// Translated address into the SDRAM image of the CRT file
	typedef logic [24:0] sdram_addr_t;

	// ********************
	// CRT hardware types
	// ********************

	// Values follow the hardware type field of the CRT header.
	// Only the types handled by cart_control are listed
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,	// Plain 8k, 16k or Ultimax ROM
		CART_OCEAN      = 16'd5,	// Ocean type 1, A and B variants
		CART_MAGIC_DESK = 16'd19,	// Magic Desk, Domark, HES Australia
		CART_EASYFLASH  = 16'd32,	// EasyFlash, boots in Ultimax mode
		CART_XBANK      = 16'd33	// EasyFlash layout without Ultimax boot
	} cart_type_e;

endpackage

/* logic/cartridge_top.sv */
/*
	Cartridge bank mapper top level.
	Connects the CRT packet loader, the bank table, the per-type
	control and the address translation. Drive the packet fields
	while loading, then the CPU bus signals during run time.
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module cartridge_top (
	input  logic                   clk32,
	input  logic                   reset_n,

	// CRT image loading
	input  logic                   cart_loading,
	input  cart_pkg::cart_type_e   cart_id,
	input  logic [7:0]             cart_exrom,
	input  logic [7:0]             cart_game,
	input  logic [15:0]            cart_bank_laddr,
	input  logic [15:0]            cart_bank_size,
	input  logic [15:0]            cart_bank_num,
	input  logic [24:0]            cart_bank_raddr,
	input  logic                   cart_bank_wr,

	// Expansion port lines
	output logic                   exrom,
	output logic                   game,

	// CPU and VIC bus
	input  logic                   romL,
	input  logic                   romH,
	input  logic                   UMAXromH,
	input  logic                   IOE,
	input  logic                   mem_write,
	output logic                   mem_write_out,
	input  logic [15:0]            addr_in,
	input  logic [7:0]             data_in,
	output cart_pkg::sdram_addr_t  addr_out
);

	logic                        tbl_wr;
	logic [`CART_SLOT_BITS-1:0]  tbl_slot;
	cart_pkg::bank_t             tbl_lo;
	cart_pkg::bank_t             tbl_hi;
	logic                        tbl_lo_en;
	logic                        tbl_hi_en;
	logic [7:0]                  bank_cnt;
	logic [`CART_SLOT_BITS-1:0]  rd_slot;
	cart_pkg::bank_t             rd_lo;
	cart_pkg::bank_t             rd_hi;
	cart_pkg::bank_t             bank_lo;
	cart_pkg::bank_t             bank_hi;
	logic                        exrom_ovr;
	logic                        game_ovr;

	assign exrom = exrom_ovr;
	assign game  = game_ovr;

	// ********************
	// Loading path
	// ********************
	crt_bank_loader crt_bank_loader_inst (
		.clk32, .cart_loading, .cart_bank_wr, .cart_bank_num, .cart_bank_laddr,
		.cart_bank_size, .cart_bank_raddr, .tbl_wr, .tbl_slot, .tbl_lo, .tbl_hi,
		.tbl_lo_en, .tbl_hi_en, .bank_cnt
	);

	bank_table bank_table_inst (
		.clk32, .tbl_wr, .tbl_slot, .tbl_lo, .tbl_hi, .tbl_lo_en, .tbl_hi_en,
		.rd_slot, .rd_lo, .rd_hi
	);

	// ********************
	// Run time mapping
	// ********************
	cart_control cart_control_inst (
		.clk32, .reset_n, .cart_id, .cart_exrom, .cart_game, .bank_cnt, .IOE,
		.mem_write, .addr_in, .data_in, .rd_lo, .rd_hi, .rd_slot, .bank_lo,
		.bank_hi, .exrom_ovr, .game_ovr
	);

	addr_translate addr_translate_inst (
		.reset_n, .romL, .romH, .UMAXromH, .mem_write, .addr_in, .bank_lo,
		.bank_hi, .exrom_ovr, .game_ovr, .addr_out, .mem_write_out
	);

endmodule

/* logic/crt_bank_loader.sv */
/*
	CRT chip packet loader.
	Each cart_bank_wr strobe describes one chip packet; this block
	registers the matching bank table write and counts the loaded
	packets since the last rising edge of cart_loading.
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module crt_bank_loader (
	input  logic                        clk32,
	input  logic                        cart_loading,
	input  logic                        cart_bank_wr,
	input  logic [15:0]                 cart_bank_num,
	input  logic [15:0]                 cart_bank_laddr,	// C64 load address of the packet
	input  logic [15:0]                 cart_bank_size,
	input  logic [24:0]                 cart_bank_raddr,	// Where the packet landed in SDRAM
	output logic                        tbl_wr,
	output logic [`CART_SLOT_BITS-1:0]  tbl_slot,
	output cart_pkg::bank_t             tbl_lo,
	output cart_pkg::bank_t             tbl_hi,
	output logic                        tbl_lo_en,
	output logic                        tbl_hi_en,
	output logic [7:0]                  bank_cnt
);

	logic            old_loading;
	logic            is_low;	// Packet starts in the romL window
	cart_pkg::bank_t raddr_bank;

	assign raddr_bank = cart_bank_raddr[`CART_WINDOW_BITS +: $bits(cart_pkg::bank_t)];
	assign is_low     = (cart_bank_laddr <= `CART_LO_LIMIT);

	// Packet counter, restarted for every new image
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (!old_loading && cart_loading)
			bank_cnt <= '0;
		if (cart_bank_wr)
			bank_cnt <= bank_cnt + 8'd1;
	end

	// ********************
	// Table write request
	// ********************
	always_ff @(posedge clk32) begin
		tbl_wr    <= cart_bank_wr && (cart_bank_num < `CART_SLOTS);
		tbl_slot  <= cart_bank_num[`CART_SLOT_BITS-1:0];
		tbl_lo    <= raddr_bank;
		tbl_lo_en <= is_low;
		if (is_low) begin
			tbl_hi    <= raddr_bank + 7'd1;	// 16k packet, upper half follows
			tbl_hi_en <= (cart_bank_size > `CART_8K);
		end else begin
			tbl_hi    <= raddr_bank;
			tbl_hi_en <= 1'b1;
		end
	end

endmodule

/* tests/cartridge_chk.sv */
/*
	Concurrent checks on the mapper top level, bound into
	cartridge_top. Failures are counted for the testbench summary.
*/

`timescale 1ns/1ns

module cartridge_chk (
	input logic                  clk32,
	input logic                  reset_n,
	input logic                  exrom,
	input logic                  game,
	input logic                  romL,
	input logic                  romH,
	input logic                  UMAXromH,
	input logic                  mem_write,
	input logic                  mem_write_out,
	input logic [15:0]           addr_in,
	input cart_pkg::sdram_addr_t addr_out
);

	int assert_fails = 0;

	// ********************
	// Line state
	// ********************
	reset_lines: assert property (@(posedge clk32) reset_n |=> (exrom && game))
		else begin
			assert_fails++;
			$error("exrom or game not inactive after a reset cycle");
		end

	// No ROM select, no remapping
	addr_passthrough: assert property (@(posedge clk32)
		!(romL || romH || UMAXromH) |-> (addr_out == cart_pkg::sdram_addr_t'(addr_in)))
		else begin
			assert_fails++;
			$error("addr_out differs from addr_in with no ROM select");
		end

	write_gated: assert property (@(posedge clk32) mem_write_out |-> mem_write)
		else begin
			assert_fails++;
			$error("mem_write_out high without mem_write");
		end

endmodule

bind cartridge_top cartridge_chk cartridge_chk_inst (
	.clk32, .reset_n, .exrom, .game, .romL, .romH, .UMAXromH, .mem_write,
	.mem_write_out, .addr_in, .addr_out
);

/* tests/cartridge_tb.sv */
/*
	Directed testbench for the cartridge bank mapper.
	Loads small CRT images through the packet strobe, then checks
	bank switching, EXROM/GAME and address translation per type.
*/

`timescale 1ns/1ns
`include "cart_cfg.svh"

module cartridge_tb;

	localparam int TIMEOUT_CYCLES = 2000;	// All tests take roughly 300 cycles
	localparam cart_pkg::sdram_addr_t ROM_BASE = 25'h100000;

	logic                  clk32 = 1'b0;
	logic                  reset_n;
	logic                  cart_loading;
	logic                  cart_bank_wr;
	cart_pkg::cart_type_e  cart_id;
	logic [7:0]            cart_exrom;
	logic [7:0]            cart_game;
	logic [15:0]           cart_bank_laddr;
	logic [15:0]           cart_bank_size;
	logic [15:0]           cart_bank_num;
	logic [24:0]           cart_bank_raddr;
	logic                  romL;
	logic                  romH;
	logic                  UMAXromH;
	logic                  IOE;
	logic                  mem_write;
	logic [15:0]           addr_in;
	logic [7:0]            data_in;
	logic                  exrom;
	logic                  game;
	logic                  mem_write_out;
	cart_pkg::sdram_addr_t addr_out;

	// Reference model of the bank table and the packet count
	cart_pkg::bank_t lo_model [`CART_SLOTS];
	cart_pkg::bank_t hi_model [`CART_SLOTS];
	int              loaded_cnt;

	integer      seed = 32'h1a29;
	logic [15:0] offset;		// Window offset used for all ROM reads
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycle_cnt = 0;

	always #2 clk32 = ~clk32;

	cartridge_top cartridge_top_inst (
		.clk32, .reset_n, .cart_loading, .cart_id, .cart_exrom, .cart_game,
		.cart_bank_laddr, .cart_bank_size, .cart_bank_num, .cart_bank_raddr,
		.cart_bank_wr, .exrom, .game, .romL, .romH, .UMAXromH, .IOE, .mem_write,
		.mem_write_out, .addr_in, .data_in, .addr_out
	);

	// ********************
	// Compare tasks
	// ********************
	task automatic check_addr(input string name, input cart_pkg::sdram_addr_t got,
	                          input cart_pkg::sdram_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bank(input string name, input cart_pkg::bank_t got,
	                          input cart_pkg::bank_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ********************
	// Reference model
	// ********************
	function automatic cart_pkg::sdram_addr_t rom_addr(input cart_pkg::bank_t bank,
	                                                   input logic [15:0] addr);
		rom_addr = ROM_BASE + cart_pkg::sdram_addr_t'(bank) * cart_pkg::sdram_addr_t'(`CART_8K)
		         + cart_pkg::sdram_addr_t'(addr % 16'(`CART_8K));
	endfunction

	// Magic Desk decodes fewer bank bits for small images
	function automatic cart_pkg::bank_t md_bank(input int count, input logic [7:0] data);
		int width;
		width = (count <= 16) ? 4 : (count <= 32) ? 5 : (count <= 64) ? 6 : 7;
		md_bank = cart_pkg::bank_t'(data & ((8'd1 << width) - 8'd1));
	endfunction

	function automatic logic [24:0] rand_raddr();
		rand_raddr = 25'($random(seed));
	endfunction

	// ********************
	// Bus tasks
	// ********************
	task automatic begin_load;
		@(posedge clk32);
		cart_loading <= 1'b1;
		@(posedge clk32);	// Counter clears here
		loaded_cnt = 0;
	endtask

	task automatic end_load;
		@(posedge clk32);
		cart_loading <= 1'b0;
		@(posedge clk32);
	endtask

	task automatic send_packet(input logic [15:0] num, input logic [15:0] laddr,
	                           input logic [15:0] size, input logic [24:0] raddr);
		cart_pkg::bank_t bank;
		bank = cart_pkg::bank_t'(raddr >> `CART_WINDOW_BITS);
		loaded_cnt++;
		if (num < 16'(`CART_SLOTS)) begin
			if (laddr <= 16'(`CART_LO_LIMIT)) begin
				lo_model[num[`CART_SLOT_BITS-1:0]] = bank;
				if (size > 16'(`CART_8K))
					hi_model[num[`CART_SLOT_BITS-1:0]] = bank + 7'd1;
			end else
				hi_model[num[`CART_SLOT_BITS-1:0]] = bank;
		end
		@(posedge clk32);
		cart_bank_num <= num;
		cart_bank_laddr <= laddr;
		cart_bank_size <= size;
		cart_bank_raddr <= raddr;
		cart_bank_wr <= 1'b1;
		@(posedge clk32);
		cart_bank_wr <= 1'b0;
	endtask

	task automatic load_8k_image(input int count);
		begin_load();
		for (int i = 0; i < count; i++)
			send_packet(16'(i), 16'h8000, 16'h2000, rand_raddr());
		end_load();
	endtask

	// sel is {UMAXromH, romH, romL}
	task automatic rom_read(input logic [2:0] sel, input logic [15:0] addr,
	                        output cart_pkg::sdram_addr_t result);
		@(posedge clk32);
		{UMAXromH, romH, romL} <= sel;
		mem_write <= 1'b0;
		addr_in <= addr;
		@(negedge clk32);
		result = addr_out;
		@(posedge clk32);
		{UMAXromH, romH, romL} <= 3'b000;
	endtask

	task automatic check_banks(input cart_pkg::bank_t exp_lo, input cart_pkg::bank_t exp_hi);
		cart_pkg::sdram_addr_t result;
		rom_read(3'b001, 16'h8000 | offset, result);
		check_bank("romL bank", cart_pkg::bank_t'(result >> `CART_WINDOW_BITS), exp_lo);
		rom_read(3'b010, 16'hA000 | offset, result);
		check_bank("romH bank", cart_pkg::bank_t'(result >> `CART_WINDOW_BITS), exp_hi);
	endtask

	task automatic ioe_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk32);
		IOE <= 1'b1;
		mem_write <= 1'b1;
		addr_in <= addr;
		data_in <= data;
		@(posedge clk32);	// Registers load on this edge
		IOE <= 1'b0;
		mem_write <= 1'b0;
	endtask

	task automatic check_lines(input bit exp_exrom, input bit exp_game);
		@(negedge clk32);
		check_line("exrom", exrom, exp_exrom);
		check_line("game", game, exp_game);
	endtask

	// One reset cycle and then the boot values of the new type
	task automatic set_type(input cart_pkg::cart_type_e id);
		@(posedge clk32);
		cart_id <= id;
		repeat (2) @(posedge clk32);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d errors", name, errors - start_errors);
	endtask

	// ********************
	// Tests
	// ********************
	task automatic test_generic_16k;
		int start_errors;
		cart_pkg::sdram_addr_t result;
		start_errors = errors;
		offset = 16'($random(seed)) & 16'h1FFF;
		@(posedge clk32);
		cart_exrom <= 8'h00;
		cart_game <= 8'h00;
		begin_load();
		send_packet(16'd0, 16'h8000, 16'h2000, rand_raddr());
		send_packet(16'd0, 16'hA000, 16'h2000, rand_raddr());
		end_load();
		check_lines(1'b0, 1'b0);
		rom_read(3'b001, 16'h8000 | offset, result);
		check_addr("addr_out", result, rom_addr(lo_model[0], offset));
		rom_read(3'b010, 16'hA000 | offset, result);
		check_addr("addr_out", result, rom_addr(hi_model[0], offset));
		rom_read(3'b100, offset, result);	// Character ROM fetch from the upper 4k
		check_addr("addr_out", result, rom_addr(hi_model[0], 16'h0) + 25'h1000 + 25'(offset[11:0]));
		finish_test("generic_16k", start_errors);
	endtask

	task automatic test_ocean;
		int start_errors;
		start_errors = errors;
		set_type(cart_pkg::CART_OCEAN);
		check_lines(1'b0, 1'b0);
		ioe_write(16'hDE00, 8'h05);
		check_banks(7'd5, 7'd5);
		begin_load();
		for (int i = 0; i < 32; i++)
			send_packet(16'(i), 16'h8000, 16'h2000, rand_raddr());
		repeat (2) @(posedge clk32);
		check_lines(1'b0, loaded_cnt > `CART_OCEAN_B_COUNT);
		send_packet(16'd32, 16'h8000, 16'h2000, rand_raddr());
		end_load();
		check_lines(1'b0, loaded_cnt > `CART_OCEAN_B_COUNT);
		finish_test("ocean", start_errors);
	endtask

	task automatic test_magic_desk;
		int start_errors;
		start_errors = errors;
		set_type(cart_pkg::CART_MAGIC_DESK);
		check_lines(1'b0, 1'b1);
		check_banks(7'd0, 7'd0);
		load_8k_image(16);
		ioe_write(16'hDE00, 8'h8F);
		check_lines(1'b1, 1'b1);
		check_banks(md_bank(loaded_cnt, 8'h8F), 7'd0);
		load_8k_image(40);
		ioe_write(16'hDE00, 8'h3A);
		check_lines(1'b0, 1'b1);
		check_banks(md_bank(loaded_cnt, 8'h3A), 7'd0);
		finish_test("magic_desk", start_errors);
	endtask

	task automatic test_easyflash;
		int start_errors;
		start_errors = errors;
		begin_load();
		for (int s = 0; s < 4; s++)
			send_packet(16'(s), 16'h8000, 16'h4000, rand_raddr());
		// High half first, so an 8k low packet must leave the high entry alone
		for (int s = 4; s < 8; s++) begin
			send_packet(16'(s), 16'hA000, 16'h2000, rand_raddr());
			send_packet(16'(s), 16'h8000, 16'h2000, rand_raddr());
		end
		send_packet(16'd70, 16'h8000, 16'h4000, rand_raddr());	// Out of range so slot 6 stays
		end_load();
		set_type(cart_pkg::CART_EASYFLASH);
		check_lines(1'b1, 1'b0);
		check_banks(lo_model[0], hi_model[0]);
		ioe_write(16'hDE00, 8'h05);
		check_banks(lo_model[5], hi_model[5]);
		ioe_write(16'hDE00, 8'h06);
		check_banks(lo_model[6], hi_model[6]);
		ioe_write(16'hDE02, 8'h04);
		check_lines(1'b1, 1'b1);
		set_type(cart_pkg::CART_XBANK);
		check_lines(1'b0, 1'b0);
		check_banks(lo_model[0], hi_model[0]);
		finish_test("easyflash", start_errors);
	endtask

	task automatic test_ultimax_write;
		int start_errors;
		start_errors = errors;
		set_type(cart_pkg::CART_EASYFLASH);
		check_lines(1'b1, 1'b0);
		@(posedge clk32);
		romL <= 1'b1;
		mem_write <= 1'b1;
		addr_in <= 16'h8123;
		@(negedge clk32);
		check_line("mem_write_out", mem_write_out, 1'b0);
		check_addr("addr_out", addr_out, 25'h8123);	// Writes are never remapped
		@(posedge clk32);
		romL <= 1'b0;
		addr_in <= 16'h0400;
		@(negedge clk32);
		check_line("mem_write_out", mem_write_out, 1'b1);
		@(posedge clk32);
		mem_write <= 1'b0;
		finish_test("ultimax_write", start_errors);
	endtask

	// ********************
	// Run control
	// ********************
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk32);
			cycle_cnt++;
		end
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int assert_fails;
		reset_n = 1'b1;
		cart_loading = 1'b0;
		cart_bank_wr = 1'b0;
		cart_id = cart_pkg::CART_GENERIC;
		cart_exrom = 8'hFF;
		cart_game = 8'hFF;
		cart_bank_laddr = '0;
		cart_bank_size = '0;
		cart_bank_num = '0;
		cart_bank_raddr = '0;
		{UMAXromH, romH, romL} = 3'b000;
		IOE = 1'b0;
		mem_write = 1'b0;
		addr_in = '0;
		data_in = '0;
		repeat (4) @(posedge clk32);
		reset_n <= 1'b0;
		test_generic_16k();
		test_ocean();
		test_magic_desk();
		test_easyflash();
		test_ultimax_write();
		assert_fails = cartridge_top_inst.cartridge_chk_inst.assert_fails;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
		         tests, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
